//--- bench/clockGen.sv
//////////////////////////////////////////////////
// testbench clock and reset source
// 4 ns clock, reset held high for 3 rising edges
//////////////////////////////////////////////////

`timescale 1ns/100ps

module clockGen (
    output logic o_clock,
    output logic o_reset
);

    initial o_clock = 1'b0;
    always #2 o_clock = ~o_clock;                 // 4 ns period

    initial begin
        o_reset = 1'b1;
        repeat (3) @(posedge o_clock);
        o_reset <= 1'b0;                          // released on the third edge
    end

endmodule

//--- bench/pdp8Tb.sv
//////////////////////////////////////////////////
// testbench for the PDP-8/L style CPU
// loads programs through the console switches,
// runs them and examines core and lamps
//////////////////////////////////////////////////

`timescale 1ns/100ps

module pdp8Tb import pdp8Pkg::*; ();

    localparam consoleKeys_t K_LOAD  = 6'b100000;
    localparam consoleKeys_t K_DEP   = 6'b010000;
    localparam consoleKeys_t K_EXAM  = 6'b001000;
    localparam consoleKeys_t K_START = 6'b000100;
    localparam consoleKeys_t K_CONT  = 6'b000010;
    localparam int MEM_CYCLES = 140;              // all tests, with margin
    localparam int KEY_PRESSES = 80;              // each costs about 8 clocks
    localparam int LIMIT = 5 * MEM_CYCLES + 8 * KEY_PRESSES + 200;

    logic         CLOCK, RESET;
    pdp8Word_t    switchReg;
    consoleKeys_t keys;
    panelLamps_t  lamps;
    logic         memStart;
    int           errors = 0;
    int           cycles = 0;
    int           testErr;

    clockGen clocks (.o_clock(CLOCK), .o_reset(RESET));

    pdp8Top #(.CORE_WORDS(4096)) DUT (
        .CLOCK(CLOCK), .RESET(RESET), .i_switchReg(switchReg), .i_keys(keys),
        .o_lamps(lamps), .o_memStart(memStart)
    );

    //////////////////////////////////////////////////
    // watchdog
    always @(posedge CLOCK) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("timeout: run went past %0d clocks", LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic checkValue(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("CHECK FAILED at %0t: %s got %o expected %o", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic pressKey(input consoleKeys_t k);
        @(posedge CLOCK);
        keys <= k;
        repeat (2) @(posedge CLOCK);              // held 2 clocks, acts on release
        keys <= '0;
    endtask

    task automatic loadAddress(input pdp8Word_t a);
        @(posedge CLOCK);
        switchReg <= a;
        pressKey(K_LOAD);
        repeat (3) @(posedge CLOCK);              // pulse then MA/PC load
    endtask

    task automatic waitMemCycle();
        int n;
        n = 0;
        @(negedge CLOCK);
        while (!memStart && n < 20) begin
            @(negedge CLOCK);
            n++;
        end
        if (!memStart) begin
            $display("console memory cycle never started at %0t", $time);
            errors++;
        end
        repeat (4) @(negedge CLOCK);              // back in IDLE, lamps settled
    endtask

    task automatic depositBlock(input pdp8Word_t a, input pdp8Word_t words[$]);
        loadAddress(a);
        foreach (words[i]) begin
            @(posedge CLOCK);
            switchReg <= words[i];                // held until TS2 takes it
            pressKey(K_DEP);
            waitMemCycle();
        end
    endtask

    task automatic examine(output pdp8Word_t mb, output pdp8Word_t ma);
        pressKey(K_EXAM);
        waitMemCycle();
        mb = lamps.mb;
        ma = lamps.ma;
    endtask

    task automatic runUntilHalt(input pdp8Word_t a);
        int n;
        n = 0;
        loadAddress(a);
        pressKey(K_START);
        repeat (3) @(posedge CLOCK);              // run set by now
        @(negedge CLOCK);
        while (lamps.run && n < 400) begin
            @(negedge CLOCK);
            n++;
        end
        if (lamps.run) begin
            $display("program at %o did not halt", a);
            errors++;
        end
    endtask

    task automatic endTest(input string name);
        $display("test %s: %s", name, (errors == testErr) ? "ok" : "errors");
        testErr = errors;
    endtask

    //////////////////////////////////////////////////
    // tests
    initial begin
        pdp8Word_t words[$];
        pdp8Word_t base, mb, ma, a, b, c, v, expAc, savedAc;
        logic [12:0] sum;
        logic expLink;
        int n;

        keys      = '0;
        switchReg = '0;
        testErr   = 0;
        void'($urandom(29571));

        @(negedge RESET);
        @(negedge CLOCK);
        checkValue("run", lamps.run, 0);
        checkValue("majorState", lamps.majorState, START);
        checkValue("o_memStart", memStart, 0);
        endTest("reset state");

        // deposit then examine at a random address
        base = 12'o1000 + pdp8Word_t'($urandom % 12'o400);
        words = {};
        repeat (4) words.push_back(pdp8Word_t'($urandom));
        depositBlock(base, words);
        loadAddress(base);
        foreach (words[i]) begin
            examine(mb, ma);
            checkValue("lamps.mb", mb, words[i]);
            checkValue("lamps.ma", ma, base + i);
        end
        endTest("deposit and examine");

        // TAD TAD AND DCA ISZ(skip) JMS, JMP I back, HLT
        a = pdp8Word_t'($urandom);
        b = pdp8Word_t'($urandom);
        c = pdp8Word_t'($urandom);
        depositBlock(12'o0200, '{12'o1050, 12'o1051, 12'o0052, 12'o3053,
                                 12'o2054, 12'o7402, 12'o4060, 12'o7402});
        depositBlock(12'o0050, '{a, b, c, 12'o0000, 12'o7777});
        depositBlock(12'o0060, '{12'o0000, 12'o5460});
        runUntilHalt(12'o0200);
        sum = {1'b0, a} + {1'b0, b};              // AC and L were cleared by start
        checkValue("lamps.link", lamps.link, sum[12]);
        checkValue("lamps.ma", lamps.ma, 12'o0210);
        checkValue("lamps.ir", lamps.ir, OPR);    // HLT was the last fetch
        loadAddress(12'o0053);
        examine(mb, ma);
        checkValue("core[0053]", mb, sum[11:0] & c);
        examine(mb, ma);
        checkValue("core[0054]", mb, 0);
        loadAddress(12'o0060);
        examine(mb, ma);
        checkValue("core[0060]", mb, 12'o0207);   // JMS return address
        endTest("memory reference program");

        // CLA SZA CMA CMA IAC RAL RAL RAR SZA IAC SNA CMA HLT
        words = '{12'o7200, 12'o7440, 12'o7040, 12'o7040, 12'o7001, 12'o7004,
                  12'o7004, 12'o7010, 12'o7440, 12'o7001, 12'o7450, 12'o7040,
                  12'o7402};
        depositBlock(12'o0400, words);
        runUntilHalt(12'o0400);
        expAc = 0;                                // cleared by start and CLA
        expLink = 0;
        if (expAc != 0) expAc = ~expAc;           // SZA on zero skips this CMA
        expAc = ~expAc;                           // CMA
        {expLink, expAc} = {expLink, expAc} + 13'd1;           // IAC
        {expLink, expAc} = {expAc, expLink};                   // RAL
        {expLink, expAc} = {expAc, expLink};                   // RAL
        {expLink, expAc} = {expAc[0], expLink, expAc[11:1]};   // RAR
        if (expAc != 0) {expLink, expAc} = {expLink, expAc} + 13'd1;    // SZA falls to IAC
        if (expAc == 0) expAc = ~expAc;           // SNA falls to CMA only on zero
        checkValue("lamps.ac", lamps.ac, expAc);
        checkValue("lamps.link", lamps.link, expLink);
        checkValue("lamps.ma", lamps.ma, 12'o0400 + words.size());
        endTest("operate groups");

        // TAD I 0010 uses the pointer after increment
        v = pdp8Word_t'($urandom);
        depositBlock(12'o0010, '{12'o0077});
        depositBlock(12'o0100, '{v});
        depositBlock(12'o0500, '{12'o1410, 12'o7402});
        runUntilHalt(12'o0500);
        checkValue("lamps.ac", lamps.ac, v);
        loadAddress(12'o0010);
        examine(mb, ma);
        checkValue("core[0010]", mb, 12'o0100);
        endTest("auto-index");

        // IAC, JMP back, stopped and continued
        depositBlock(12'o0600, '{12'o7001, 12'o5200});
        loadAddress(12'o0600);
        pressKey(K_START);
        repeat (20) @(posedge CLOCK);
        keys.stop <= 1'b1;
        n = 0;
        @(negedge CLOCK);
        while (lamps.run && n < 5) begin          // one memory cycle
            @(negedge CLOCK);
            n++;
        end
        if (lamps.run) begin
            $display("stop switch did not halt the loop within one memory cycle");
            errors++;
        end
        savedAc = lamps.ac;
        @(posedge CLOCK);
        keys.stop <= 1'b0;
        pressKey(K_CONT);
        repeat (20) @(posedge CLOCK);
        @(negedge CLOCK);
        checkValue("lamps.run", lamps.run, 1);
        if (lamps.ac == savedAc) begin
            $display("loop made no progress after continue");
            errors++;
        end
        @(posedge CLOCK);
        keys.stop <= 1'b1;
        repeat (15) @(posedge CLOCK);
        keys.stop <= 1'b0;
        @(negedge CLOCK);
        checkValue("lamps.run", lamps.run, 0);
        endTest("stop and continue");

        n = errors + DUT.control.checks.failCount;
        $display("checks failed %0d, assertions failed %0d, clocks %0d",
                 errors, DUT.control.checks.failCount, cycles);
        if (n == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- bench/pdp8Top_asserts.sv
//////////////////////////////////////////////////
// concurrent checks on the cycle sequencer
// bound into every cycleControl instance, counts
// its own failures for the testbench summary
//////////////////////////////////////////////////

`timescale 1ns/100ps

module pdp8Top_asserts import pdp8Pkg::*; (
    input logic        CLOCK,
    input logic        RESET,
    input timeState_t  timeState,
    input logic        run,
    input keyCmd_t     i_cmd,
    input logic        o_memStart
);

    int failCount = 0;

    // TS1 lasts one clock only
    memStartPulse: assert property (@(posedge CLOCK) disable iff (RESET)
        o_memStart |=> !o_memStart)
        else begin
            $error("memory start held for two clocks");
            failCount++;
        end

    // TS1 TS2 TS3 TS4 then back to IDLE
    cycleLength: assert property (@(posedge CLOCK) disable iff (RESET)
        o_memStart |-> ##4 (timeState == IDLE))
        else begin
            $error("memory cycle did not return to IDLE after 4 clocks");
            failCount++;
        end

    // only start or continue may set RUN
    runRise: assert property (@(posedge CLOCK) disable iff (RESET)
        $rose(run) |-> $past(i_cmd.start || i_cmd.cont))
        else begin
            $error("run rose without a start or continue command");
            failCount++;
        end

endmodule

bind cycleControl pdp8Top_asserts checks (
    .CLOCK(CLOCK), .RESET(RESET), .timeState(timeState),
    .run(run), .i_cmd(i_cmd), .o_memStart(o_memStart)
);

//--- run.sh
#!/bin/sh
# build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module pdp8Tb \
        -Mdir obj_dir -f sim.f; then
    echo "compile failed"
    exit 1
fi

if ! ./obj_dir/Vpdp8Tb > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
exit 1

//--- sim.f
source/pdp8Pkg.sv
source/coreMemory.sv
source/operateUnit.sv
source/consoleKeys.sv
source/cycleControl.sv
source/pdp8Top.sv
bench/clockGen.sv
bench/pdp8Top_asserts.sv
bench/pdp8Tb.sv

//--- source/consoleKeys.sv
//////////////////////////////////////////////////
// front panel momentary switches
// a falling switch level gives a one clock command
// pulse, one command per clock by priority
//////////////////////////////////////////////////

`timescale 1ns/100ps

module consoleKeys import pdp8Pkg::*; (
    input  logic         CLOCK,
    input  logic         RESET,
    input  consoleKeys_t i_keys,
    output keyCmd_t      o_cmd
);

    keyCmd_t levels;                              // the five momentary levels
    keyCmd_t lastLevels;                          // levels one clock ago
    keyCmd_t released;                            // 1 then 0

    assign levels   = {i_keys.loadAddr, i_keys.deposit, i_keys.examine,
                       i_keys.start, i_keys.cont};
    assign released = lastLevels & ~levels;

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            lastLevels <= '0;
            o_cmd      <= '0;
        end else begin
            lastLevels <= levels;
            o_cmd      <= '0;
            if (released.loadAddr) o_cmd.loadAddr <= 1'b1;   // highest priority
            else if (released.examine) o_cmd.examine <= 1'b1;
            else if (released.deposit) o_cmd.deposit <= 1'b1;
            else if (released.cont) o_cmd.cont <= 1'b1;
            else if (released.start) o_cmd.start <= 1'b1;    // lowest
        end
    end

endmodule

//--- source/coreMemory.sv
//////////////////////////////////////////////////
// local core store of the CPU
// read address taken in TS1, data one clock later
// MB written back to the same address in TS3
//////////////////////////////////////////////////

`timescale 1ns/100ps

module coreMemory import pdp8Pkg::*; #(
    parameter int CORE_WORDS = 4096
) (
    input  logic      CLOCK,
    input  pdp8Word_t i_addr,
    input  logic      i_readEn,
    input  logic      i_writeEn,
    input  pdp8Word_t i_writeData,
    output pdp8Word_t o_readData
);

    localparam int ADDR_BITS = $clog2(CORE_WORDS);

    pdp8Word_t            core [CORE_WORDS];      // inferred block ram
    logic [ADDR_BITS-1:0] wordAddr;

    assign wordAddr = i_addr[ADDR_BITS-1:0];      // upper MA bits drop out for small cores

    always_ff @(posedge CLOCK) begin
        if (i_writeEn) core[wordAddr] <= i_writeData;
        if (i_readEn) o_readData <= core[wordAddr];   // registered read port
    end

endmodule

//--- source/cycleControl.sv
//////////////////////////////////////////////////
// time state and major state sequencer
// holds AC, L, PC, MA, MB, IR and RUN, runs one
// memory cycle per IDLE..TS4 pass and serves the
// console while the machine is stopped
//////////////////////////////////////////////////

`timescale 1ns/100ps

module cycleControl import pdp8Pkg::*; (
    input  logic        CLOCK,
    input  logic        RESET,
    input  keyCmd_t     i_cmd,
    input  logic        i_stop,
    input  pdp8Word_t   i_switchReg,
    input  opResult_t   i_res,
    input  pdp8Word_t   i_readData,
    output pdp8Word_t   o_addr,
    output logic        o_readEn,
    output logic        o_writeEn,
    output pdp8Word_t   o_writeData,
    output instrWord_t  o_opMb,
    output pdp8Word_t   o_ac,
    output logic        o_link,
    output panelLamps_t o_lamps,
    output logic        o_memStart
);

    timeState_t  timeState;
    majorState_t majorState;
    logic        run;
    logic        depositCyc;                      // START cycle writes the switches
    pdp8Word_t   ac, pc, ma;
    logic        link;
    instrWord_t  mb;
    opcode_t     ir;
    instrWord_t  coreWord;                        // word coming out of the core
    pdp8Word_t   mbWord;
    pdp8Word_t   pcNext;                          // PC after a possible skip

    assign coreWord = i_readData;
    assign mbWord   = mb;
    assign pcNext   = i_res.g2Skip ? pc + 12'd1 : pc;

    // memory side, MA addresses both the read and the write back
    assign o_addr      = ma;
    assign o_readEn    = (timeState == TS1);
    assign o_writeEn   = (timeState == TS3);
    assign o_writeData = mb;
    assign o_memStart  = (timeState == TS1);

    assign o_opMb = mb;
    assign o_ac   = ac;
    assign o_link = link;

    always_comb begin
        o_lamps.ac         = ac;
        o_lamps.link       = link;
        o_lamps.ma         = ma;
        o_lamps.mb         = mb;
        o_lamps.ir         = ir;
        o_lamps.majorState = majorState;
        o_lamps.run        = run;
    end

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            timeState  <= IDLE;
            majorState <= START;
            run        <= 1'b0;
            depositCyc <= 1'b0;
            ac         <= '0;
            link       <= 1'b0;
            pc         <= '0;
            ma         <= '0;
        end else begin
            case (timeState)

                //////////////////////////////////////////////////
                // pick the next cycle or serve the console
                IDLE: begin
                    if (!run) begin
                        if (i_cmd.loadAddr) begin
                            ma <= i_switchReg;
                            pc <= i_switchReg;
                        end else if (i_cmd.examine || i_cmd.deposit) begin
                            ma         <= pc;
                            pc         <= pc + 12'd1;
                            majorState <= START;
                            depositCyc <= i_cmd.deposit;
                            timeState  <= TS1;
                        end else if (i_cmd.cont) begin
                            run <= 1'b1;                // keep the major state
                        end else if (i_cmd.start) begin
                            ac         <= '0;
                            link       <= 1'b0;
                            majorState <= START;
                            run        <= 1'b1;
                        end
                    end else if (majorState == START) begin
                        ma <= pc;
                        if (i_stop) run <= 1'b0;        // stop between instructions
                        else begin
                            pc         <= pc + 12'd1;
                            majorState <= FETCH;
                            timeState  <= TS1;
                        end
                    end else timeState <= TS1;          // defer or exec cycle next
                end

                TS1: timeState <= TS2;                  // core read under way

                //////////////////////////////////////////////////
                // core word arrives, modify by major state into MB
                TS2: begin
                    case (majorState)
                        FETCH: begin
                            ir <= coreWord.memRef.opcode;
                            mb <= coreWord;
                        end
                        DEFER: mb <= (ma[11:3] == 9'd1) ? i_readData + 12'd1 : i_readData;
                        EXEC: begin
                            case (ir)
                                ISZ: mb <= i_readData + 12'd1;
                                DCA: mb <= ac;
                                JMS: mb <= pc;               // return address
                                default: mb <= coreWord;
                            endcase
                        end
                        default: mb <= depositCyc ? i_switchReg : i_readData;
                    endcase
                    timeState <= TS3;
                end

                TS3: timeState <= TS4;                  // MB goes back to core

                //////////////////////////////////////////////////
                // finish the instruction, choose the next cycle
                TS4: begin
                    case (majorState)
                        FETCH: begin
                            case (ir)
                                JMP: begin
                                    if (mb.memRef.indirect) begin
                                        ma         <= i_res.effAddr;
                                        majorState <= DEFER;
                                    end else begin
                                        pc         <= i_res.effAddr;
                                        majorState <= START;
                                    end
                                end
                                IOT: majorState <= START;    // no I/O, plain fetch
                                OPR: begin
                                    if (!mb.operate.group) begin
                                        ac   <= i_res.g1Ac;
                                        link <= i_res.g1Link;
                                    end else if (!mb.operate.micro[MO_G3]) begin
                                        pc <= pcNext;
                                        ac <= i_res.g2Ac;
                                        if (mb.operate.micro[MO_HLT]) begin
                                            run <= 1'b0;
                                            ma  <= pcNext;  // lamps show the resume address
                                        end
                                    end
                                    majorState <= START;
                                end
                                default: begin               // AND TAD ISZ DCA JMS
                                    ma         <= i_res.effAddr;
                                    majorState <= mb.memRef.indirect ? DEFER : EXEC;
                                end
                            endcase
                        end
                        DEFER: begin
                            if (ir == JMP) begin
                                pc         <= mbWord;
                                majorState <= START;
                            end else begin
                                ma         <= mbWord;
                                majorState <= EXEC;
                            end
                        end
                        EXEC: begin
                            case (ir)
                                AND: ac <= ac & mbWord;
                                TAD: begin
                                    ac   <= i_res.tadAc;
                                    link <= i_res.tadLink;
                                end
                                ISZ: if (mbWord == '0) pc <= pc + 12'd1;
                                DCA: ac <= '0;
                                JMS: pc <= ma + 12'd1;
                                default: ;
                            endcase
                            majorState <= START;
                        end
                        default: depositCyc <= 1'b0;         // console cycle done
                    endcase
                    timeState <= IDLE;
                end

                default: timeState <= IDLE;
            endcase
        end
    end

endmodule

//--- source/operateUnit.sv
//////////////////////////////////////////////////
// combinational data path of the CPU
// group 1 and group 2 results, TAD sum and
// effective address, all from the current MB
//////////////////////////////////////////////////

`timescale 1ns/100ps

module operateUnit import pdp8Pkg::*; (
    input  instrWord_t i_mb,
    input  pdp8Word_t  i_ac,
    input  logic       i_link,
    input  pdp8Word_t  i_ma,
    input  pdp8Word_t  i_switchReg,
    output opResult_t  o_res
);

    logic [7:0] mo;                               // micro-op bits
    pdp8Word_t  rawAc;                            // after clear, complement, increment
    logic       rawLink;

    assign mo = i_mb.operate.micro;

    always_comb begin
        // group 1 in order: clear, complement, then +1 carrying into link
        {rawLink, rawAc} = {(mo[MO_CLL] ? 1'b0 : i_link) ^ mo[MO_CML],
                            (mo[MO_CLA] ? '0 : i_ac) ^ (mo[MO_CMA] ? WORD_MAX : '0)}
                           + {12'd0, mo[MO_IAC]};

        // rotate field is RAR, RAL, BSW
        case (mo[3:1])
            3'b001: {o_res.g1Link, o_res.g1Ac} = {rawLink, rawAc[5:0], rawAc[11:6]}; // BSW
            3'b010: {o_res.g1Link, o_res.g1Ac} = {rawAc, rawLink};                   // RAL
            3'b011: {o_res.g1Link, o_res.g1Ac} = {rawAc[10:0], rawLink, rawAc[11]};  // RTL
            3'b100: {o_res.g1Link, o_res.g1Ac} = {rawAc[0], rawLink, rawAc[11:1]};   // RAR
            3'b101: {o_res.g1Link, o_res.g1Ac} = {rawAc[1:0], rawLink, rawAc[11:2]}; // RTR
            default: {o_res.g1Link, o_res.g1Ac} = {rawLink, rawAc};                  // no rotate
        endcase

        // group 2 skip, OR of the sensed conditions, flipped by the reverse bit
        o_res.g2Skip = ((mo[MO_SMA] & i_ac[11])
                      | (mo[MO_SZA] & (i_ac == '0))
                      | (mo[MO_SNL] & i_link)) ^ mo[MO_REV];

        // group 2 AC, clear first, then OR in the switch register
        o_res.g2Ac = (mo[MO_CLA] ? '0 : i_ac) | (mo[MO_OSR] ? i_switchReg : '0);

        // TAD, carry out toggles the link
        {o_res.tadLink, o_res.tadAc} = {i_link, i_ac} + {1'b0, i_mb};

        // page zero or the page of the instruction in MA
        o_res.effAddr = {i_mb.memRef.currentPage ? i_ma[11:7] : 5'b0, i_mb.memRef.offset};
    end

endmodule

//--- source/pdp8Pkg.sv
//////////////////////////////////////////////////
// shared types and codes for the PDP-8/L style CPU
// every module pulls these in through a wildcard
// import in its header
//////////////////////////////////////////////////

package pdp8Pkg;

    typedef logic [11:0] pdp8Word_t;              // one machine word

    localparam pdp8Word_t WORD_MAX = 12'o7777;

    typedef enum logic [2:0] {
        AND, TAD, ISZ, DCA, JMS, JMP, IOT, OPR    // octal 0..7 in the top three bits
    } opcode_t;

    typedef enum logic [1:0] {START, FETCH, DEFER, EXEC} majorState_t;

    typedef enum logic [2:0] {IDLE, TS1, TS2, TS3, TS4} timeState_t;

    // micro-op bit positions inside operate.micro
    localparam int unsigned MO_CLA = 7;           // both groups
    localparam int unsigned MO_CLL = 6;           // group 1 from here
    localparam int unsigned MO_CMA = 5;
    localparam int unsigned MO_CML = 4;
    localparam int unsigned MO_IAC = 0;
    localparam int unsigned MO_SMA = 6;           // group 2 from here
    localparam int unsigned MO_SZA = 5;
    localparam int unsigned MO_SNL = 4;
    localparam int unsigned MO_REV = 3;
    localparam int unsigned MO_OSR = 2;
    localparam int unsigned MO_HLT = 1;
    localparam int unsigned MO_G3  = 0;           // set means group 3, not run here

    typedef struct packed {
        opcode_t    opcode;
        logic       indirect;
        logic       currentPage;
        logic [6:0] offset;
    } memRefWord_t;

    typedef struct packed {
        opcode_t    opcode;
        logic       group;                        // 0 group 1, 1 group 2
        logic [7:0] micro;
    } operateWord_t;

    // same 12 bits, read as memory reference or as operate
    typedef union packed {
        memRefWord_t  memRef;
        operateWord_t operate;
    } instrWord_t;

    typedef struct packed {
        logic loadAddr, deposit, examine, start, cont, stop;
    } consoleKeys_t;                              // raw switch levels

    typedef struct packed {
        logic loadAddr, deposit, examine, start, cont;
    } keyCmd_t;                                   // one clock per release

    typedef struct packed {
        pdp8Word_t   ac;
        logic        link;
        pdp8Word_t   ma;
        pdp8Word_t   mb;
        opcode_t     ir;
        majorState_t majorState;
        logic        run;
    } panelLamps_t;

    typedef struct packed {
        pdp8Word_t g1Ac;
        logic      g1Link;
        pdp8Word_t g2Ac;
        logic      g2Skip;
        pdp8Word_t tadAc;
        logic      tadLink;
        pdp8Word_t effAddr;
    } opResult_t;

endpackage

//--- source/pdp8Top.sv
//////////////////////////////////////////////////
// top level of the PDP-8/L style CPU
// front panel in, lamps out, core held inside
//////////////////////////////////////////////////

`timescale 1ns/100ps

module pdp8Top import pdp8Pkg::*; #(
    parameter int CORE_WORDS = 4096               // words of local core
) (
    input  logic         CLOCK,
    input  logic         RESET,
    input  pdp8Word_t    i_switchReg,
    input  consoleKeys_t i_keys,
    output panelLamps_t  o_lamps,
    output logic         o_memStart
);

    keyCmd_t    keyCmd;
    instrWord_t opMb;                             // MB as seen by the data path
    pdp8Word_t  ac;
    logic       link;
    pdp8Word_t  coreAddr;                         // also MA for the effective address
    pdp8Word_t  writeData;
    pdp8Word_t  readData;
    logic       readEn;
    logic       writeEn;
    opResult_t  opRes;

    consoleKeys keys (
        .CLOCK(CLOCK), .RESET(RESET),
        .i_keys(i_keys), .o_cmd(keyCmd)
    );

    cycleControl control (
        .CLOCK(CLOCK), .RESET(RESET),
        .i_cmd(keyCmd), .i_stop(i_keys.stop),     // stop is a level, no pulse
        .i_switchReg(i_switchReg), .i_res(opRes), .i_readData(readData),
        .o_addr(coreAddr), .o_readEn(readEn), .o_writeEn(writeEn),
        .o_writeData(writeData), .o_opMb(opMb), .o_ac(ac), .o_link(link),
        .o_lamps(o_lamps), .o_memStart(o_memStart)
    );

    operateUnit dataPath (
        .i_mb(opMb), .i_ac(ac), .i_link(link), .i_ma(coreAddr),
        .i_switchReg(i_switchReg), .o_res(opRes)
    );

    coreMemory #(.CORE_WORDS(CORE_WORDS)) core (
        .CLOCK(CLOCK), .i_addr(coreAddr), .i_readEn(readEn),
        .i_writeEn(writeEn), .i_writeData(writeData), .o_readData(readData)
    );

endmodule
